// File: verilog/axi_mem_pkg.sv
package axi_mem_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------

  // Byte address on AW and AR
  localparam int ADDR_WIDTH = 32;

  // AxLEN field, beats minus one
  // Only 0 to 15 used here
  localparam int LEN_WIDTH = 8;

  // ----------------------------------------
  // Response codes
  // ----------------------------------------
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // ----------------------------------------
  // Burst type codes
  // ----------------------------------------
  localparam logic [1:0] BURST_FIXED = 2'b00;
  localparam logic [1:0] BURST_INCR  = 2'b01;
  // Not supported, answered with SLVERR
  localparam logic [1:0] BURST_WRAP  = 2'b10;

  // ----------------------------------------
  // Channel state machine
  // ----------------------------------------
  typedef enum logic [2:0] {
    IDLE    = 3'd0,  // Waiting for AW or AR
    WR_DATA = 3'd1,  // Taking W beats
    WR_RESP = 3'd2,  // Holding B until bready
    RD_MEM  = 3'd3,  // One memory read per beat
    RD_DATA = 3'd4   // Holding R until rready
  } ctrl_state_t;

endpackage

// File: verilog/axi_burst_counter.sv
`timescale 1ns/1ps

module axi_burst_counter #(
  parameter int DEPTH      = 1024,
  parameter int DATA_WIDTH = 32
) (
  input  logic                               aclk,
  input  logic                               aresetn,
  // Control from the state machine
  input  logic                               load,
  input  logic                               step,
  input  logic                               is_read,
  // Write request
  input  logic [axi_mem_pkg::ADDR_WIDTH-1:0] awaddr,
  input  logic [axi_mem_pkg::LEN_WIDTH-1:0]  awlen,
  input  logic [1:0]                         awburst,
  // Read request
  input  logic [axi_mem_pkg::ADDR_WIDTH-1:0] araddr,
  input  logic [axi_mem_pkg::LEN_WIDTH-1:0]  arlen,
  input  logic [1:0]                         arburst,
  // Current beat
  output logic [$clog2(DEPTH)-1:0]           word_addr,
  output logic                               beat_last,
  output logic                               beat_err
);

  import axi_mem_pkg::*;

  // Byte offset bits within one word
  localparam int BYTE_BITS = $clog2(DATA_WIDTH / 8);
  // Word index bits of the byte address
  localparam int IDX_W     = ADDR_WIDTH - BYTE_BITS;
  localparam logic [IDX_W-1:0]      DEPTH_IDX = IDX_W'(DEPTH);
  localparam logic [ADDR_WIDTH-1:0] WORD_STEP = ADDR_WIDTH'(DATA_WIDTH / 8);

  logic [ADDR_WIDTH-1:0] addr_q;
  logic [LEN_WIDTH-1:0]  remain_q;
  logic [1:0]            burst_q;
  logic [IDX_W-1:0]      word_idx;

  // ----------------------------------------
  // Beat address and flags
  // ----------------------------------------
  assign word_idx  = addr_q[ADDR_WIDTH-1:BYTE_BITS];
  assign word_addr = word_idx[$clog2(DEPTH)-1:0];
  // Range check against the memory size
  assign beat_err  = (word_idx >= DEPTH_IDX);
  assign beat_last = (remain_q == '0);

  // ----------------------------------------
  // Load and advance
  // ----------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      addr_q   <= '0;
      remain_q <= '0;
      burst_q  <= BURST_FIXED;
    end else if (load) begin
      addr_q   <= is_read ? araddr  : awaddr;
      remain_q <= is_read ? arlen   : awlen;
      burst_q  <= is_read ? arburst : awburst;
    end else if (step) begin
      case (burst_q)
        // Same word every beat
        BURST_FIXED: addr_q <= addr_q;
        BURST_INCR:  addr_q <= addr_q + WORD_STEP;
        // WRAP is rejected upstream, walk it like INCR
        default:     addr_q <= addr_q + WORD_STEP;
      endcase
      if (remain_q != '0) begin
        remain_q <= remain_q - 1'b1;
      end
    end
  end

endmodule

// File: verilog/axi_mem_sram.sv
`timescale 1ns/1ps

module axi_mem_sram #(
  parameter int DATA_WIDTH = 32,
  parameter int DEPTH      = 1024
) (
  input  logic                     aclk,
  input  logic                     cs,
  input  logic                     we,
  input  logic [DATA_WIDTH/8-1:0]  wstrb,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  logic [DATA_WIDTH-1:0]    wdata,
  output logic [DATA_WIDTH-1:0]    rdata
);

  localparam int NBYTES = DATA_WIDTH / 8;

  // ----------------------------------------
  // Storage
  // ----------------------------------------
  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // Write path, one enable per byte lane
  always_ff @(posedge aclk) begin
    if (cs && we) begin
      for (int i = 0; i < NBYTES; i++) begin
        if (wstrb[i]) begin
          mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
        end
      end
    end
  end

  // Read port
  // Output register only loads on a read, holds otherwise
  always_ff @(posedge aclk) begin
    if (cs && !we) begin
      rdata <= mem[addr];
    end
  end

endmodule

// File: verilog/axi_mem_fsm.sv
`timescale 1ns/1ps

module axi_mem_fsm #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                    aclk,
  input  logic                    aresetn,
  // Write address channel
  input  logic                    awvalid,
  input  logic [1:0]              awburst,
  output logic                    awready,
  // Write data channel
  input  logic                    wvalid,
  input  logic                    wlast,
  input  logic [DATA_WIDTH/8-1:0] wstrb,
  output logic                    wready,
  // Write response channel
  input  logic                    bready,
  output logic                    bvalid,
  output logic [1:0]              bresp,
  // Read address channel
  input  logic                    arvalid,
  input  logic [1:0]              arburst,
  output logic                    arready,
  // Read data channel
  input  logic                    rready,
  output logic                    rvalid,
  output logic [1:0]              rresp,
  output logic                    rlast,
  output logic [DATA_WIDTH-1:0]   rdata,
  // Burst counter
  input  logic                    beat_last,
  input  logic                    beat_err,
  output logic                    cnt_load,
  output logic                    cnt_step,
  output logic                    cnt_is_read,
  // Memory port
  output logic                    mem_cs,
  output logic                    mem_we,
  output logic [DATA_WIDTH/8-1:0] mem_wstrb,
  input  logic [DATA_WIDTH-1:0]   sram_rdata
);

  import axi_mem_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_nxt;

  // Sticky error for the burst in flight
  logic err;
  logic err_nxt;

  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic ar_fire;
  logic r_fire;

  // ----------------------------------------
  // Channel handshakes
  // ----------------------------------------

  // Write has priority, so AR waits while awvalid is up
  // Both address channels stay closed while reset is applied
  assign awready = aresetn && (state == IDLE);
  assign arready = aresetn && (state == IDLE) && !awvalid;
  assign wready  = (state == WR_DATA);
  assign bvalid  = (state == WR_RESP);
  assign rvalid  = (state == RD_DATA);

  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;
  assign b_fire  = bvalid && bready;
  assign ar_fire = arvalid && arready;
  assign r_fire  = rvalid && rready;

  // ----------------------------------------
  // Counter control
  // ----------------------------------------
  assign cnt_load    = aw_fire || ar_fire;
  // Only sampled on load, and AR loads only when awvalid is low
  assign cnt_is_read = !awvalid;
  // Step on every accepted beat
  assign cnt_step    = w_fire || r_fire;

  // ----------------------------------------
  // Memory strobes
  // ----------------------------------------
  assign mem_we    = (state == WR_DATA);
  assign mem_wstrb = w_fire ? wstrb : '0;

  always_comb begin
    mem_cs = 1'b0;
    case (state)
      // Write in the W handshake cycle
      WR_DATA: mem_cs = w_fire && !beat_err && !err;
      // One read per beat, skipped on error
      RD_MEM:  mem_cs = !beat_err && !err;
      default: mem_cs = 1'b0;
    endcase
  end

  // ----------------------------------------
  // Response outputs
  // ----------------------------------------
  assign bresp = err ? RESP_SLVERR : RESP_OKAY;
  assign rresp = err ? RESP_SLVERR : RESP_OKAY;
  assign rlast = rvalid && beat_last;

  // Zero data on a failed read beat
  // sram_rdata holds until the next read, so R stays stable on a stall
  assign rdata = err ? '0 : sram_rdata;

  // ----------------------------------------
  // Next state and error
  // ----------------------------------------
  always_comb begin
    state_nxt = state;
    err_nxt   = err;
    case (state)
      IDLE: begin
        if (aw_fire) begin
          state_nxt = WR_DATA;
          err_nxt   = (awburst == BURST_WRAP);
        end else if (ar_fire) begin
          state_nxt = RD_MEM;
          err_nxt   = (arburst == BURST_WRAP);
        end
      end
      WR_DATA: begin
        if (w_fire) begin
          // Out of range, or wlast not on the counted last beat
          err_nxt = err || beat_err || (wlast != beat_last);
          if (beat_last) begin
            state_nxt = WR_RESP;
          end
        end
      end
      WR_RESP: begin
        if (b_fire) begin
          state_nxt = IDLE;
        end
      end
      RD_MEM: begin
        err_nxt   = err || beat_err;
        state_nxt = RD_DATA;
      end
      RD_DATA: begin
        if (r_fire) begin
          state_nxt = beat_last ? IDLE : RD_MEM;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= IDLE;
      err   <= 1'b0;
    end else begin
      state <= state_nxt;
      err   <= err_nxt;
    end
  end

endmodule

// File: verilog/axi_mem_top.sv
`timescale 1ns/1ps

module axi_mem_top #(
  parameter int DATA_WIDTH = 32,
  parameter int DEPTH      = 1024
) (
  input  logic                               aclk,
  input  logic                               aresetn,
  // Write address channel
  input  logic [axi_mem_pkg::ADDR_WIDTH-1:0] awaddr,
  input  logic [axi_mem_pkg::LEN_WIDTH-1:0]  awlen,
  input  logic [1:0]                         awburst,
  input  logic                               awvalid,
  output logic                               awready,
  // Write data channel
  input  logic [DATA_WIDTH-1:0]              wdata,
  input  logic [DATA_WIDTH/8-1:0]            wstrb,
  input  logic                               wlast,
  input  logic                               wvalid,
  output logic                               wready,
  // Write response channel
  output logic [1:0]                         bresp,
  output logic                               bvalid,
  input  logic                               bready,
  // Read address channel
  input  logic [axi_mem_pkg::ADDR_WIDTH-1:0] araddr,
  input  logic [axi_mem_pkg::LEN_WIDTH-1:0]  arlen,
  input  logic [1:0]                         arburst,
  input  logic                               arvalid,
  output logic                               arready,
  // Read data channel
  output logic [DATA_WIDTH-1:0]              rdata,
  output logic [1:0]                         rresp,
  output logic                               rlast,
  output logic                               rvalid,
  input  logic                               rready
);

  // ----------------------------------------
  // Internal nets
  // ----------------------------------------

  // State machine to counter
  logic cnt_load;
  logic cnt_step;
  logic cnt_is_read;

  // Counter to state machine
  logic beat_last;
  logic beat_err;

  // Memory port
  logic                     mem_cs;
  logic                     mem_we;
  logic [DATA_WIDTH/8-1:0]  mem_wstrb;
  logic [$clog2(DEPTH)-1:0] mem_addr;
  logic [DATA_WIDTH-1:0]    sram_rdata;

  // ----------------------------------------
  // Channel state machine
  // ----------------------------------------
  axi_mem_fsm #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_fsm (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .awvalid     (awvalid),
    .awburst     (awburst),
    .awready     (awready),
    .wvalid      (wvalid),
    .wlast       (wlast),
    .wstrb       (wstrb),
    .wready      (wready),
    .bready      (bready),
    .bvalid      (bvalid),
    .bresp       (bresp),
    .arvalid     (arvalid),
    .arburst     (arburst),
    .arready     (arready),
    .rready      (rready),
    .rvalid      (rvalid),
    .rresp       (rresp),
    .rlast       (rlast),
    .rdata       (rdata),
    .beat_last   (beat_last),
    .beat_err    (beat_err),
    .cnt_load    (cnt_load),
    .cnt_step    (cnt_step),
    .cnt_is_read (cnt_is_read),
    .mem_cs      (mem_cs),
    .mem_we      (mem_we),
    .mem_wstrb   (mem_wstrb),
    .sram_rdata  (sram_rdata)
  );

  // ----------------------------------------
  // Beat counter and address
  // ----------------------------------------
  axi_burst_counter #(
    .DEPTH      (DEPTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_counter (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .load      (cnt_load),
    .step      (cnt_step),
    .is_read   (cnt_is_read),
    .awaddr    (awaddr),
    .awlen     (awlen),
    .awburst   (awburst),
    .araddr    (araddr),
    .arlen     (arlen),
    .arburst   (arburst),
    .word_addr (mem_addr),
    .beat_last (beat_last),
    .beat_err  (beat_err)
  );

  // ----------------------------------------
  // Single-port memory
  // ----------------------------------------
  axi_mem_sram #(
    .DATA_WIDTH (DATA_WIDTH),
    .DEPTH      (DEPTH)
  ) u_sram (
    .aclk  (aclk),
    .cs    (mem_cs),
    .we    (mem_we),
    .wstrb (mem_wstrb),
    .addr  (mem_addr),
    .wdata (wdata),
    .rdata (sram_rdata)
  );

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD = 8
) (
  output logic aclk
);

  // Free running clock, starts low
  initial begin
    aclk = 1'b0;
    forever #(PERIOD / 2) aclk = ~aclk;
  end

endmodule

// File: tests/axi_mem_sva.sv
`timescale 1ns/1ps

module axi_mem_sva #(
  parameter int DATA_WIDTH = 32
) (
  input logic                               aclk,
  input logic                               aresetn,
  input logic                               awvalid,
  input logic                               awready,
  input logic [axi_mem_pkg::ADDR_WIDTH-1:0] awaddr,
  input logic [axi_mem_pkg::LEN_WIDTH-1:0]  awlen,
  input logic                               arvalid,
  input logic                               arready,
  input logic [axi_mem_pkg::ADDR_WIDTH-1:0] araddr,
  input logic                               wvalid,
  input logic                               wready,
  input logic                               bvalid,
  input logic                               bready,
  input logic [1:0]                         bresp,
  input logic                               rvalid,
  input logic                               rready,
  input logic [DATA_WIDTH-1:0]              rdata,
  input logic [1:0]                         rresp,
  input logic                               rlast,
  input logic                               mem_cs,
  input logic                               mem_we
);

  // Read from the testbench at the end of the run
  int fail_count = 0;

  // ----------------------------------------
  // Valid holds under back-pressure
  // ----------------------------------------
  a_aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen))
    else begin $error("AW dropped or changed before its handshake"); fail_count++; end

  // AR waits out a whole write when both arrive together
  a_ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else begin $error("AR dropped or changed before its handshake"); fail_count++; end

  a_b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else begin $error("B response changed while stalled"); fail_count++; end

  a_r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp) && $stable(rlast))
    else begin $error("R beat changed while stalled"); fail_count++; end

  // ----------------------------------------
  // Reset and memory strobes
  // ----------------------------------------
  a_reset_quiet: assert property (@(posedge aclk)
    !aresetn |=> !bvalid && !rvalid)
    else begin $error("Response valid high after reset"); fail_count++; end

  // Memory write only on a W handshake
  a_write_map: assert property (@(posedge aclk) disable iff (!aresetn)
    mem_cs && mem_we |-> wvalid && wready)
    else begin $error("Memory write without W handshake"); fail_count++; end

  // RD_MEM is the only state with no channel active
  a_read_map: assert property (@(posedge aclk) disable iff (!aresetn)
    mem_cs && !mem_we |-> !awready && !wready && !bvalid && !rvalid)
    else begin $error("Memory read outside RD_MEM"); fail_count++; end

endmodule

// File: tests/axi_mem_tb.sv
`timescale 1ns/1ps

module axi_mem_tb;

  import axi_mem_pkg::*;

  localparam int DEPTH = 256;
  // Cycles allowed for any single wait
  localparam int TMO   = 100;

  logic                  aclk, aresetn;
  logic [ADDR_WIDTH-1:0] awaddr, araddr;
  logic [LEN_WIDTH-1:0]  awlen, arlen;
  logic [1:0]            awburst, arburst, bresp, rresp;
  logic [31:0]           wdata, rdata;
  logic [3:0]            wstrb;
  logic                  awvalid, awready, wlast, wvalid, wready, bvalid, bready;
  logic                  arvalid, arready, rlast, rvalid, rready;

  int seed   = 50291;
  int errors = 0;
  int tests  = 0;
  int failed = 0;

  // Reference memory and per-beat buffers
  logic [31:0] model [DEPTH];
  logic [31:0] wbuf [16];
  logic [3:0]  sbuf [16];
  logic [31:0] rbuf [16];
  logic [1:0]  pbuf [16];
  logic        lbuf [16];

  tb_clock #(.PERIOD(8)) u_clk (.aclk(aclk));

  axi_mem_top #(.DATA_WIDTH(32), .DEPTH(DEPTH)) dut (.*);

  bind axi_mem_top axi_mem_sva u_sva (.*);

  task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  function automatic logic chan_ready(input int ch);
    case (ch)
      0: return awready;
      1: return wready;
      2: return bvalid;
      3: return arready;
      default: return rvalid;
    endcase
  endfunction

  // Called on a falling edge, returns on the falling edge before the transfer
  task automatic wait_chan(input int ch, input string what);
    int n;
    n = 0;
    while (!chan_ready(ch) && n < TMO) begin
      @(negedge aclk);
      n++;
    end
    if (!chan_ready(ch)) begin
      $display("Timeout waiting for %s", what);
      errors++;
    end
  endtask

  function automatic int word_of(input logic [31:0] addr, input int i, input logic [1:0] burst);
    return (burst == BURST_FIXED) ? int'(addr >> 2) : int'(addr >> 2) + i;
  endfunction

  task automatic fill_random(input int n, input logic [3:0] strb);
    for (int i = 0; i < n; i++) begin
      wbuf[i] = $random(seed);
      sbuf[i] = strb;
    end
  endtask

  // ----------------------------------------
  // Bus master
  // ----------------------------------------
  task automatic write_burst(input logic [31:0] addr, input int beats, input logic [1:0] burst,
                             input int stall_max, output logic [1:0] resp);
    int stall;
    awaddr  = addr;
    awlen   = 8'(beats - 1);
    awburst = burst;
    awvalid = 1'b1;
    wait_chan(0, "awready");
    for (int i = 0; i < beats; i++) begin
      @(negedge aclk);
      awvalid = 1'b0;
      wdata   = wbuf[i];
      wstrb   = sbuf[i];
      wlast   = (i == beats - 1);
      wvalid  = 1'b1;
      wait_chan(1, "wready");
    end
    @(negedge aclk);
    wvalid = 1'b0;
    wlast  = 1'b0;
    wait_chan(2, "bvalid");
    resp  = bresp;
    stall = {$random(seed)} % (stall_max + 1);
    // bresp must not move while bready is held low
    repeat (stall) begin
      @(negedge aclk);
      check_equal("bresp", 32'(bresp), 32'(resp));
    end
    bready = 1'b1;
    @(negedge aclk);
    bready = 1'b0;
  endtask

  task automatic read_burst(input logic [31:0] addr, input int beats, input logic [1:0] burst,
                            input int stall_max);
    int stall;
    araddr  = addr;
    arlen   = 8'(beats - 1);
    arburst = burst;
    arvalid = 1'b1;
    wait_chan(3, "arready");
    @(negedge aclk);
    arvalid = 1'b0;
    for (int i = 0; i < beats; i++) begin
      wait_chan(4, "rvalid");
      rbuf[i] = rdata;
      pbuf[i] = rresp;
      lbuf[i] = rlast;
      stall   = {$random(seed)} % (stall_max + 1);
      repeat (stall) begin
        @(negedge aclk);
        check_equal("rdata", rdata, rbuf[i]);
        check_equal("rresp", 32'(rresp), 32'(pbuf[i]));
        check_equal("rlast", 32'(rlast), 32'(lbuf[i]));
      end
      rready = 1'b1;
      @(negedge aclk);
      rready = 1'b0;
    end
  endtask

  // ----------------------------------------
  // Expected results from the burst rules
  // ----------------------------------------
  task automatic write_expect(input logic [31:0] addr, input int beats, input logic [1:0] burst,
                              input int stall_max);
    logic [1:0] resp;
    logic       bad;
    int         idx;
    bad = (burst == BURST_WRAP);
    write_burst(addr, beats, burst, stall_max, resp);
    for (int i = 0; i < beats; i++) begin
      idx = word_of(addr, i, burst);
      bad = bad || (idx >= DEPTH);
      // Byte lanes merge into the old word
      for (int b = 0; b < 4 && !bad; b++) begin
        if (sbuf[i][b]) begin
          model[idx][b*8 +: 8] = wbuf[i][b*8 +: 8];
        end
      end
    end
    check_equal("bresp", 32'(resp), bad ? 32'(RESP_SLVERR) : 32'(RESP_OKAY));
  endtask

  task automatic read_expect(input logic [31:0] addr, input int beats, input logic [1:0] burst,
                             input int stall_max);
    logic bad;
    int   idx;
    bad = (burst == BURST_WRAP);
    read_burst(addr, beats, burst, stall_max);
    for (int i = 0; i < beats; i++) begin
      idx = word_of(addr, i, burst);
      // Error sticks for the rest of the burst
      bad = bad || (idx >= DEPTH);
      check_equal("rdata", rbuf[i], bad ? 32'h0 : model[idx]);
      check_equal("rresp", 32'(pbuf[i]), bad ? 32'(RESP_SLVERR) : 32'(RESP_OKAY));
      check_equal("rlast", 32'(lbuf[i]), 32'(i == beats - 1));
    end
  endtask

  task automatic report_test(input string name, input int e0);
    tests++;
    if (errors == e0) begin
      $display("test %s ok", name);
    end else begin
      failed++;
      $display("test %s: %0d errors", name, errors - e0);
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic test_reset;
    int e0;
    e0 = errors;
    // Reset is held low from time zero
    repeat (2) @(negedge aclk);
    // No channel open while reset is applied
    check_equal("awready", 32'(awready), 32'h0);
    check_equal("arready", 32'(arready), 32'h0);
    check_equal("wready", 32'(wready), 32'h0);
    check_equal("bvalid", 32'(bvalid), 32'h0);
    check_equal("rvalid", 32'(rvalid), 32'h0);
    aresetn = 1'b1;
    @(negedge aclk);
    // Address channels open in IDLE once released
    check_equal("awready", 32'(awready), 32'h1);
    check_equal("arready", 32'(arready), 32'h1);
    report_test("reset", e0);
  endtask

  task automatic test_single;
    int e0;
    e0 = errors;
    fill_random(1, 4'hf);
    write_expect(32'h10, 1, BURST_INCR, 0);
    // Partial write over it, lanes 0 and 2
    fill_random(1, 4'b0101);
    write_expect(32'h10, 1, BURST_INCR, 0);
    read_expect(32'h10, 1, BURST_INCR, 0);
    report_test("single beat", e0);
  endtask

  task automatic test_bursts;
    int e0;
    e0 = errors;
    fill_random(8, 4'hf);
    write_expect(32'h40, 8, BURST_INCR, 0);
    read_expect(32'h40, 8, BURST_INCR, 0);
    report_test("incr burst", e0);
    e0 = errors;
    fill_random(4, 4'hf);
    write_expect(32'h80, 4, BURST_FIXED, 0);
    read_expect(32'h80, 4, BURST_FIXED, 0);
    report_test("fixed burst", e0);
  endtask

  task automatic test_range;
    int e0;
    e0 = errors;
    // Words 0 to 3 alias the beats past DEPTH
    fill_random(4, 4'hf);
    write_expect(32'h0, 4, BURST_INCR, 0);
    fill_random(4, 4'hf);
    write_expect(32'h3f0, 4, BURST_INCR, 0);
    fill_random(6, 4'hf);
    write_expect(32'h3f8, 6, BURST_INCR, 0);
    read_expect(32'h0, 4, BURST_INCR, 0);
    read_expect(32'h3f0, 4, BURST_INCR, 0);
    read_expect(32'h3f8, 4, BURST_INCR, 0);
    // WRAP write must leave the words alone
    fill_random(4, 4'hf);
    write_expect(32'h40, 4, BURST_WRAP, 0);
    read_expect(32'h40, 4, BURST_INCR, 0);
    read_expect(32'h40, 4, BURST_WRAP, 0);
    report_test("range and wrap", e0);
  endtask

  task automatic test_stalls;
    int e0;
    e0 = errors;
    fill_random(8, 4'hf);
    write_expect(32'h200, 8, BURST_INCR, 5);
    read_expect(32'h200, 8, BURST_INCR, 5);
    report_test("stalls", e0);
  endtask

  task automatic test_collision;
    int e0;
    e0 = errors;
    fill_random(1, 4'hf);
    write_expect(32'h300, 1, BURST_INCR, 0);
    // AR raised in the same cycle as AW
    fill_random(1, 4'hf);
    araddr  = 32'h300;
    arlen   = 8'd0;
    arburst = BURST_INCR;
    arvalid = 1'b1;
    write_expect(32'h300, 1, BURST_INCR, 0);
    read_expect(32'h300, 1, BURST_INCR, 0);
    report_test("write before read", e0);
  endtask

  initial begin
    aresetn = 1'b0;
    awaddr  = '0;
    awlen   = '0;
    awburst = BURST_INCR;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wlast   = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arlen   = '0;
    arburst = BURST_INCR;
    arvalid = 1'b0;
    rready  = 1'b0;
    test_reset();
    test_single();
    test_bursts();
    test_range();
    test_stalls();
    test_collision();
    if (dut.u_sva.fail_count != 0) begin
      $display("%0d bus assertions fired", dut.u_sva.fail_count);
      errors += dut.u_sva.fail_count;
    end
    $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: axi_mem.f
verilog/axi_mem_pkg.sv
verilog/axi_burst_counter.sv
verilog/axi_mem_sram.sv
verilog/axi_mem_fsm.sv
verilog/axi_mem_top.sv
tests/tb_clock.sv
tests/axi_mem_sva.sv
tests/axi_mem_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUNFLAGS  ?= +verilator+error+limit+100
TOP       ?= axi_mem_tb
FILELIST  ?= axi_mem.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
